//--- common/io_bus_pkg.sv
`default_nettype none

package io_bus_pkg;

	typedef logic [15:0] io_addr_t;   // port address
	typedef logic [31:0] io_data_t;   // cpu side data
	typedef logic [7:0]  io_byte_t;   // byte device data
	typedef logic [2:0]  io_len_t;    // bytes per access, 1 2 or 4

	// cpu request, held until the matching done
	typedef struct packed {
		logic     read_do;
		logic     write_do;
		io_addr_t address;
		io_len_t  length;
		io_data_t writedata;
	} io_req_t;

	// one bus cycle as seen by the devices
	typedef struct packed {
		io_addr_t address;
		logic     read;       // one cycle strobe
		logic     write;      // one cycle strobe
		io_len_t  datasize;   // 4 on a 32-bit cycle, else 1
		io_data_t writedata;
	} io_bus_t;

	// read data from every device, answered within the strobe cycle
	typedef struct packed {
		io_data_t hdd0;
		io_data_t hdd1;
		io_byte_t fdd0;
		io_byte_t pit;
		io_byte_t pic;
		io_byte_t rtc;
		io_byte_t uart;
		io_byte_t vga;
	} dev_rdata_t;

endpackage

`default_nettype wire

//--- common/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

	// devices that keep a port range on the fabric
	typedef enum logic [2:0] {
		DEV_HDD0,
		DEV_HDD1,
		DEV_FDD0,
		DEV_PIT,
		DEV_PIC,
		DEV_RTC,
		DEV_UART,
		DEV_VGA
	} dev_id_t;

	localparam int N_DEV = 8;

	typedef logic [N_DEV-1:0] dev_cs_t;   // indexed by dev_id_t

	localparam logic [15:0] HDD0_BASE     = 16'h01F0; // 1F0-1F7
	localparam logic [15:0] HDD0_MASK     = 16'hFFF8;
	localparam logic [15:0] HDD0_ALT      = 16'h03F6; // device control
	localparam logic [15:0] HDD0_ALT_MASK = 16'hFFFF;
	localparam logic [15:0] HDD1_BASE     = 16'h0170; // 170-177
	localparam logic [15:0] HDD1_MASK     = 16'hFFF8;
	localparam logic [15:0] HDD1_ALT      = 16'h0376;
	localparam logic [15:0] HDD1_ALT_MASK = 16'hFFFF;
	localparam logic [15:0] FDD0_BASE     = 16'h03F0; // 3F0-3F7, 3F6 goes to hdd0
	localparam logic [15:0] FDD0_MASK     = 16'hFFF8;
	localparam logic [15:0] PIT_BASE      = 16'h0040; // 40-43
	localparam logic [15:0] PIT_MASK      = 16'hFFFC;
	localparam logic [15:0] PIT_ALT       = 16'h0061; // speaker gate port
	localparam logic [15:0] PIT_ALT_MASK  = 16'hFFFF;
	localparam logic [15:0] PIC_BASE      = 16'h0020; // master
	localparam logic [15:0] PIC_MASK      = 16'hFFFE;
	localparam logic [15:0] PIC_ALT       = 16'h00A0; // slave
	localparam logic [15:0] PIC_ALT_MASK  = 16'hFFFE;
	localparam logic [15:0] RTC_BASE      = 16'h0070;
	localparam logic [15:0] RTC_MASK      = 16'hFFFE;
	localparam logic [15:0] UART_BASE     = 16'h03F8; // com1
	localparam logic [15:0] UART_MASK     = 16'hFFF8;
	localparam logic [15:0] VGA_BASE      = 16'h03B0; // mono block 3B0-3BF
	localparam logic [15:0] VGA_MASK      = 16'hFFF0;
	localparam logic [15:0] VGA_ALT       = 16'h03C0; // 3C0-3DF in one compare
	localparam logic [15:0] VGA_ALT_MASK  = 16'hFFE0;

	// clear on an hdd port means the 32-bit data register
	localparam int IO32_ADDR_BIT = 9;

endpackage

`default_nettype wire

//--- io_bridge/io_bridge.sv
`default_nettype none

module io_bridge import io_bus_pkg::*; (
	input  wire logic     clk_sys,
	input  wire logic     rst_n,

	input  wire io_req_t  cpu_req,
	input  wire logic     io32,
	input  wire io_data_t ret_data,

	output io_bus_t       bus,
	output io_data_t      cpu_read_data,
	output logic          cpu_read_done,
	output logic          cpu_write_done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,     // address out, strobes low
		ST_STROBE,   // chip selects valid, one strobe high
		ST_DATA,     // ret_data holds the strobe cycle data
		ST_DONE
	} state_t;

	state_t     state;
	io_req_t    req_q;       // latched request
	logic [1:0] beat_q;      // byte index of the current beat
	logic       mode32;      // access runs as a single 32-bit beat
	logic       wide;
	logic       last_beat;
	io_data_t   rdata_q;     // read assembly

	// io32 only counts once the first address has gone through decode
	assign wide = mode32 | ((state == ST_STROBE) & (beat_q == 2'd0) & io32);

	assign last_beat = mode32 | (({1'b0, beat_q} + 3'd1) >= req_q.length);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			req_q  <= '0;
			beat_q <= 2'd0;
			mode32 <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cpu_req.read_do | cpu_req.write_do) begin
						req_q  <= cpu_req;
						beat_q <= 2'd0;
						mode32 <= 1'b0;
						state  <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					state <= ST_STROBE;
				end
				ST_STROBE: begin
					if (beat_q == 2'd0)
						mode32 <= io32; // hdd data port, length no longer matters
					state <= ST_DATA;
				end
				ST_DATA: begin
					if (last_beat) begin
						state <= ST_DONE;
					end else begin
						beat_q <= beat_q + 2'd1;
						state  <= ST_ADDR;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && (cpu_req.read_do | cpu_req.write_do))
			rdata_q <= '0;   // bytes past the length stay zero
		else if (state == ST_DATA) begin
			if (mode32)
				rdata_q <= ret_data;
			else
				rdata_q[8*beat_q +: 8] <= ret_data[7:0];
		end
	end

	always_comb begin
		bus.address   = req_q.address + io_addr_t'(beat_q);
		bus.read      = (state == ST_STROBE) & req_q.read_do;
		bus.write     = (state == ST_STROBE) & req_q.write_do;
		bus.datasize  = wide ? 3'd4 : 3'd1;
		bus.writedata = wide ? req_q.writedata : {24'd0, req_q.writedata[8*beat_q +: 8]};
	end

	assign cpu_read_data  = rdata_q;
	assign cpu_read_done  = (state == ST_DONE) & req_q.read_do;
	assign cpu_write_done = (state == ST_DONE) & req_q.write_do;

	a_one_dir: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(bus.read && bus.write))
		else $error("read and write strobes high together");

	// the cpu drops do only after seeing done, so a longer pulse would repeat
	a_rd_done_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cpu_read_done |=> !cpu_read_done)
		else $error("read done longer than one cycle");

	a_wr_done_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cpu_write_done |=> !cpu_write_done)
		else $error("write done longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/io_decode.sv
`default_nettype none

module io_decode import io_bus_pkg::*, io_map_pkg::*; (
	input  wire logic    clk_sys,
	input  wire logic    rst_n,
	input  wire io_bus_t bus,
	output dev_cs_t      dev_cs,
	output logic         io32
);

	dev_cs_t cs_next;

	function automatic logic hit(
		input io_addr_t    addr,
		input logic [15:0] base,
		input logic [15:0] mask
	);
		return (addr & mask) == base;
	endfunction

	always_comb begin
		cs_next = '0;
		cs_next[DEV_HDD0] = hit(bus.address, HDD0_BASE, HDD0_MASK) |
			hit(bus.address, HDD0_ALT, HDD0_ALT_MASK);
		cs_next[DEV_HDD1] = hit(bus.address, HDD1_BASE, HDD1_MASK) |
			hit(bus.address, HDD1_ALT, HDD1_ALT_MASK);
		// 3F6 belongs to hdd0
		cs_next[DEV_FDD0] = hit(bus.address, FDD0_BASE, FDD0_MASK) & ~cs_next[DEV_HDD0];
		cs_next[DEV_PIT]  = hit(bus.address, PIT_BASE, PIT_MASK) |
			hit(bus.address, PIT_ALT, PIT_ALT_MASK);
		cs_next[DEV_PIC]  = hit(bus.address, PIC_BASE, PIC_MASK) |
			hit(bus.address, PIC_ALT, PIC_ALT_MASK);
		cs_next[DEV_RTC]  = hit(bus.address, RTC_BASE, RTC_MASK);
		cs_next[DEV_UART] = hit(bus.address, UART_BASE, UART_MASK);
		cs_next[DEV_VGA]  = hit(bus.address, VGA_BASE, VGA_MASK) |
			hit(bus.address, VGA_ALT, VGA_ALT_MASK);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dev_cs <= '0;
			io32   <= 1'b0;
		end else begin
			dev_cs <= cs_next;
			// data register sits below the 3xx control block
			io32   <= (cs_next[DEV_HDD0] | cs_next[DEV_HDD1]) &
				~bus.address[IO32_ADDR_BIT];
		end
	end

	// port ranges in the map must not overlap
	a_cs_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(dev_cs))
		else $error("more than one chip select for port %h", bus.address);

endmodule

`default_nettype wire

//--- verilog/io_return.sv
`default_nettype none

module io_return import io_bus_pkg::*, io_map_pkg::*; #(
	parameter io_byte_t UNMAPPED_BYTE = 8'hFF
) (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire io_bus_t    bus,
	input  wire dev_cs_t    dev_cs,
	input  wire dev_rdata_t dev_rdata,
	output io_data_t        ret_data
);

	io_byte_t byte_sel;
	io_data_t data_sel;

	always_comb begin
		if (dev_cs[DEV_FDD0])
			byte_sel = dev_rdata.fdd0;
		else if (dev_cs[DEV_PIT])
			byte_sel = dev_rdata.pit;
		else if (dev_cs[DEV_PIC])
			byte_sel = dev_rdata.pic;
		else if (dev_cs[DEV_RTC])
			byte_sel = dev_rdata.rtc;
		else if (dev_cs[DEV_UART])
			byte_sel = dev_rdata.uart;
		else if (dev_cs[DEV_VGA])
			byte_sel = dev_rdata.vga;
		else
			byte_sel = UNMAPPED_BYTE;   // open bus
	end

	// hdd ports return the full word, the bridge keeps what it needs
	always_comb begin
		if (dev_cs[DEV_HDD0])
			data_sel = dev_rdata.hdd0;
		else if (dev_cs[DEV_HDD1])
			data_sel = dev_rdata.hdd1;
		else
			data_sel = {24'd0, byte_sel};
	end

	always_ff @(posedge clk_sys) begin
		if (bus.read)
			ret_data <= data_sel;
	end

	// devices must answer within the strobe cycle
	a_rdata_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bus.read |-> !$isunknown(data_sel))
		else $error("unknown read data at port %h", bus.address);

endmodule

`default_nettype wire

//--- verilog/io_fabric_top.sv
`default_nettype none

module io_fabric_top import io_bus_pkg::*, io_map_pkg::*; #(
	parameter io_byte_t UNMAPPED_BYTE = 8'hFF
) (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,

	input  wire io_req_t    cpu_req,
	output io_data_t        cpu_read_data,
	output logic            cpu_read_done,
	output logic            cpu_write_done,

	output io_bus_t         bus,
	output dev_cs_t         dev_cs,
	input  wire dev_rdata_t dev_rdata
);

	logic     io32;       // current bus address hits a 32-bit data port
	io_data_t ret_data;   // data picked from the strobe cycle

	io_bridge io_bridge_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cpu_req        (cpu_req),
		.io32           (io32),
		.ret_data       (ret_data),
		.bus            (bus),
		.cpu_read_data  (cpu_read_data),
		.cpu_read_done  (cpu_read_done),
		.cpu_write_done (cpu_write_done)
	);

	io_decode io_decode_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.bus     (bus),
		.dev_cs  (dev_cs),
		.io32    (io32)
	);

	io_return #(
		.UNMAPPED_BYTE (UNMAPPED_BYTE)
	) io_return_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus       (bus),
		.dev_cs    (dev_cs),
		.dev_rdata (dev_rdata),
		.ret_data  (ret_data)
	);

endmodule

`default_nettype wire

//--- verif/io_fabric_tests.svh
`ifndef IO_FABRIC_TESTS_SVH
`define IO_FABRIC_TESTS_SVH

// legacy port map, -1 for an open port
function automatic int dev_of_port(input io_addr_t a);
	if ((a >= 16'h01F0 && a <= 16'h01F7) || a == 16'h03F6)
		return DEV_HDD0;   // 3F6 goes to the disk, not the floppy
	if ((a >= 16'h0170 && a <= 16'h0177) || a == 16'h0376)
		return DEV_HDD1;
	if (a >= 16'h03F0 && a <= 16'h03F7)
		return DEV_FDD0;
	if ((a >= 16'h0040 && a <= 16'h0043) || a == 16'h0061)
		return DEV_PIT;
	if (a == 16'h0020 || a == 16'h0021 || a == 16'h00A0 || a == 16'h00A1)
		return DEV_PIC;
	if (a == 16'h0070 || a == 16'h0071)
		return DEV_RTC;
	if (a >= 16'h03F8 && a <= 16'h03FF)
		return DEV_UART;
	if (a >= 16'h03B0 && a <= 16'h03DF)
		return DEV_VGA;
	return -1;
endfunction

function automatic dev_cs_t cs_of_port(input io_addr_t a);
	dev_cs_t cs;
	int      d;
	cs = '0;
	d  = dev_of_port(a);
	if (d >= 0)
		cs[d] = 1'b1;
	return cs;
endfunction

// hdd data register, below the 3xx block
function automatic logic wide_port(input io_addr_t a);
	int d;
	d = dev_of_port(a);
	return (d == DEV_HDD0 || d == DEV_HDD1) && !a[9];
endfunction

function automatic io_data_t hdd_word(input io_addr_t a);
	return (dev_of_port(a) == DEV_HDD1) ? ({a, a} ^ 32'hA5A5A5A5) : {a, a};
endfunction

function automatic io_byte_t byte_at_port(input io_addr_t a);
	int       d;
	io_data_t w;
	d = dev_of_port(a);
	if (d < 0)
		return 8'hFF;   // open bus fill
	if (d == DEV_HDD0 || d == DEV_HDD1) begin
		w = hdd_word(a);
		return w[7:0];
	end
	return a[7:0] ^ (io_byte_t'(d) * 8'h11);
endfunction

// one cpu request, every beat checked at the falling edge
task automatic run_access(input logic is_write, input io_addr_t addr, input io_len_t len,
	input io_data_t wdata);
	io_req_t  req;
	logic     wide;
	int       beats;
	int       seen;
	logic     done_seen;
	io_data_t exp_rd;
	io_addr_t baddr;
	wide   = wide_port(addr);
	beats  = wide ? 1 : int'(len);
	exp_rd = '0;
	if (wide)
		exp_rd = hdd_word(addr);
	else
		for (int k = 0; k < len; k++)
			exp_rd[8*k +: 8] = byte_at_port(addr + io_addr_t'(k));
	req           = '0;
	req.read_do   = !is_write;
	req.write_do  = is_write;
	req.address   = addr;
	req.length    = len;
	req.writedata = wdata;
	@(posedge clk_sys);
	cpu_req <= req;
	seen      = 0;
	done_seen = 1'b0;
	while (!done_seen) begin
		@(negedge clk_sys);
		if (bus.read || bus.write) begin
			baddr = addr + io_addr_t'(seen);
			check_value(bus.read, !is_write, $sformatf("port %h read strobe", baddr));
			check_value(bus.write, is_write, $sformatf("port %h write strobe", baddr));
			check_value(bus.address, baddr, $sformatf("beat %0d address", seen));
			check_value(bus.datasize, wide ? 3'd4 : 3'd1, $sformatf("port %h datasize", baddr));
			check_value(dev_cs, cs_of_port(baddr), $sformatf("port %h chip select", baddr));
			if (is_write)
				check_value(bus.writedata, wide ? wdata : {24'd0, wdata[8*seen +: 8]},
					$sformatf("port %h writedata", baddr));
			seen++;
		end
		if (cpu_read_done || cpu_write_done) begin
			done_seen = 1'b1;
			check_value(cpu_read_done, !is_write, $sformatf("port %h read done", addr));
			check_value(cpu_write_done, is_write, $sformatf("port %h write done", addr));
			check_value(seen, beats, $sformatf("port %h strobe count", addr));
			if (!is_write)
				check_value(cpu_read_data, exp_rd, $sformatf("port %h read data", addr));
		end
	end
	@(posedge clk_sys);
	cpu_req <= '0;
endtask

task automatic check_reset_state();
	@(negedge clk_sys);
	check_value(cpu_read_done, 1'b0, "read done after reset");
	check_value(cpu_write_done, 1'b0, "write done after reset");
	check_value(bus.read, 1'b0, "read strobe after reset");
	check_value(bus.write, 1'b0, "write strobe after reset");
	check_value(dev_cs, '0, "chip selects after reset");
endtask

task automatic read_each_range();
	io_addr_t ports [N_RANGE_READS];
	ports = '{16'h01F0, 16'h01F7, 16'h03F6, 16'h0170, 16'h0376, 16'h03F0, 16'h03F5,
		16'h0040, 16'h0043, 16'h0061, 16'h0020, 16'h00A1, 16'h0070, 16'h0071,
		16'h03F8, 16'h03FF, 16'h03B0, 16'h03C4, 16'h03DF, 16'h0300, 16'h0000,
		16'h03E0, 16'h0062};
	foreach (ports[i])
		run_access(1'b0, ports[i], 3'd1, 32'd0);
endtask

task automatic read_multi_byte();
	io_addr_t ports [N_MULTI_READS];
	io_len_t  lens [N_MULTI_READS];
	ports = '{16'h03F8, 16'h03F8, 16'h0040, 16'h03C0, 16'h03EE, 16'h006E};
	lens  = '{3'd2, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4};   // last two cross into a range
	foreach (ports[i])
		run_access(1'b0, ports[i], lens[i], 32'd0);
endtask

task automatic access_hdd_ports();
	io_addr_t ports [N_HDD_ACCESSES];
	io_len_t  lens [N_HDD_ACCESSES];
	ports = '{16'h01F0, 16'h03F6, 16'h0170, 16'h0376};
	lens  = '{3'd4, 3'd1, 3'd2, 3'd1};
	foreach (ports[i])
		run_access(1'b0, ports[i], lens[i], 32'd0);
endtask

task automatic write_beats();
	io_addr_t ports [N_WRITES];
	io_len_t  lens [N_WRITES];
	io_data_t data [N_WRITES];
	ports = '{16'h03F8, 16'h03F8, 16'h01F0, 16'h0020, 16'h0300};
	lens  = '{3'd1, 3'd4, 3'd4, 3'd2, 3'd1};
	data  = '{32'h0000005A, 32'h11223344, 32'h89ABCDEF, 32'h0000A55A, 32'h000000C3};
	foreach (ports[i])
		run_access(1'b1, ports[i], lens[i], data[i]);
endtask

task automatic random_accesses();
	io_addr_t addr;
	io_len_t  len;
	logic     is_write;
	io_data_t wdata;
	for (int i = 0; i < N_RANDOM; i++) begin
		addr = io_addr_t'($urandom % 32'h400);   // the whole legacy map sits below 400
		case ($urandom % 3)
			0: len = 3'd1;
			1: len = 3'd2;
			default: len = 3'd4;
		endcase
		is_write = ($urandom % 2) != 0;
		wdata    = $urandom;
		run_access(is_write, addr, len, wdata);
	end
endtask

`endif

//--- verif/io_fabric_tb.sv
`default_nettype none

module io_fabric_tb import io_bus_pkg::*, io_map_pkg::*; ();

	localparam int N_RANGE_READS  = 23;
	localparam int N_MULTI_READS  = 6;
	localparam int N_HDD_ACCESSES = 4;
	localparam int N_WRITES       = 5;
	localparam int N_RANDOM       = 40;
	localparam int N_ACCESSES     = N_RANGE_READS + N_MULTI_READS + N_HDD_ACCESSES +
		N_WRITES + N_RANDOM;
	localparam int TIMEOUT_CYCLES = N_ACCESSES * 14 + 100;   // 4 beats plus request and drop

	logic       clk_sys;
	logic       rst_n;
	io_req_t    cpu_req;
	io_data_t   cpu_read_data;
	logic       cpu_read_done;
	logic       cpu_write_done;
	io_bus_t    bus;
	dev_cs_t    dev_cs;
	dev_rdata_t dev_rdata;

	int          n_checks;
	int          n_errors;
	int          cycles;

	io_fabric_top #(
		.UNMAPPED_BYTE (8'hFF)
	) io_fabric_top_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cpu_req        (cpu_req),
		.cpu_read_data  (cpu_read_data),
		.cpu_read_done  (cpu_read_done),
		.cpu_write_done (cpu_write_done),
		.bus            (bus),
		.dev_cs         (dev_cs),
		.dev_rdata      (dev_rdata)
	);

	// byte devices give the low port byte xor their id times 11
	function automatic dev_rdata_t device_data(input io_addr_t a);
		dev_rdata_t d;
		d.hdd0 = {a, a};
		d.hdd1 = {a, a} ^ 32'hA5A5A5A5;
		d.fdd0 = a[7:0] ^ (io_byte_t'(DEV_FDD0) * 8'h11);
		d.pit  = a[7:0] ^ (io_byte_t'(DEV_PIT) * 8'h11);
		d.pic  = a[7:0] ^ (io_byte_t'(DEV_PIC) * 8'h11);
		d.rtc  = a[7:0] ^ (io_byte_t'(DEV_RTC) * 8'h11);
		d.uart = a[7:0] ^ (io_byte_t'(DEV_UART) * 8'h11);
		d.vga  = a[7:0] ^ (io_byte_t'(DEV_VGA) * 8'h11);
		return d;
	endfunction

	assign dev_rdata = device_data(bus.address);   // answers within the strobe cycle

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		n_checks++;
		assert (got === exp)
			else begin
				n_errors++;
				$display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
			end
	endtask

	`include "io_fabric_tests.svh"

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		n_checks = 0;
		n_errors = 0;
		void'($urandom(14712));
		rst_n    = 1'b0;
		cpu_req  = '0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		check_reset_state();
		read_each_range();
		read_multi_byte();
		access_hdd_ports();
		write_beats();
		random_accesses();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- io_fabric.f
+incdir+verif
common/io_bus_pkg.sv
common/io_map_pkg.sv
io_bridge/io_bridge.sv
verilog/io_decode.sv
verilog/io_return.sv
verilog/io_fabric_top.sv
verif/io_fabric_tb.sv
